//--- common/wasm_pkg.sv
// shared widths, format codes, opcode table and control encodings, imported by every wasm block
`default_nettype none

package wasm_pkg;

    localparam int WINDOW_BYTES  = 8;
    localparam int WINDOW_W      = WINDOW_BYTES * 8;
    localparam int VALUE_W       = 32;
    localparam int ADV_W         = 16;  // wide enough to jump a whole section
    localparam int LEB_MAX_BYTES = 5;
    localparam int LEB_CNT_W     = 3;
    localparam int DEPTH_W       = 4;
    localparam int SLOT_W        = 8;

    // "\0asm" followed by version 1, little endian
    localparam logic [WINDOW_W-1:0] WASM_MAGIC_VERSION = 64'h0000_0001_6d73_6100;
    localparam logic [7:0]          SEC_CODE           = 8'h0a;

    localparam logic [7:0] OP_UNREACHABLE = 8'h00;
    localparam logic [7:0] OP_NOP         = 8'h01;
    localparam logic [7:0] OP_BLOCK       = 8'h02;
    localparam logic [7:0] OP_LOOP        = 8'h03;
    localparam logic [7:0] OP_END         = 8'h0b;
    localparam logic [7:0] OP_DROP        = 8'h1a;
    localparam logic [7:0] OP_SELECT      = 8'h1b;
    localparam logic [7:0] OP_LOCAL_GET   = 8'h20;
    localparam logic [7:0] OP_LOCAL_SET   = 8'h21;
    localparam logic [7:0] OP_LOCAL_TEE   = 8'h22;
    localparam logic [7:0] OP_I32_LOAD    = 8'h28;
    localparam logic [7:0] OP_I32_STORE   = 8'h36;
    localparam logic [7:0] OP_I32_CONST   = 8'h41;
    localparam logic [7:0] OP_I32_EQZ     = 8'h45;
    localparam logic [7:0] OP_I32_EQ      = 8'h46;
    localparam logic [7:0] OP_I32_NE      = 8'h47;
    localparam logic [7:0] OP_I32_LT_S    = 8'h48;
    localparam logic [7:0] OP_I32_LT_U    = 8'h49;
    localparam logic [7:0] OP_I32_GT_S    = 8'h4a;
    localparam logic [7:0] OP_I32_GT_U    = 8'h4b;
    localparam logic [7:0] OP_I32_LE_S    = 8'h4c;
    localparam logic [7:0] OP_I32_LE_U    = 8'h4d;
    localparam logic [7:0] OP_I32_GE_S    = 8'h4e;
    localparam logic [7:0] OP_I32_GE_U    = 8'h4f;
    localparam logic [7:0] OP_I32_ADD     = 8'h6a;
    localparam logic [7:0] OP_I32_SUB     = 8'h6b;
    localparam logic [7:0] OP_I32_AND     = 8'h71;
    localparam logic [7:0] OP_I32_OR      = 8'h72;
    localparam logic [7:0] OP_I32_SHL     = 8'h74;
    localparam logic [7:0] OP_I32_SHR_S   = 8'h75;
    localparam logic [7:0] OP_I32_SHR_U   = 8'h76;
    localparam logic [7:0] OP_I32_ROTL    = 8'h77;
    localparam logic [7:0] OP_I32_ROTR    = 8'h78;

    localparam logic [4:0] ALU_ADD    = 5'd0;
    localparam logic [4:0] ALU_SUB    = 5'd1;
    localparam logic [4:0] ALU_AND    = 5'd2;
    localparam logic [4:0] ALU_OR     = 5'd3;
    localparam logic [4:0] ALU_SELECT = 5'd4;
    localparam logic [4:0] ALU_EQZ    = 5'd5;
    localparam logic [4:0] ALU_EQ     = 5'd6;
    localparam logic [4:0] ALU_LT_U   = 5'd7;
    localparam logic [4:0] ALU_GT_U   = 5'd8;
    localparam logic [4:0] ALU_LE_U   = 5'd9;
    localparam logic [4:0] ALU_GE_U   = 5'd10;
    localparam logic [4:0] ALU_LT_S   = 5'd11;
    localparam logic [4:0] ALU_GT_S   = 5'd12;
    localparam logic [4:0] ALU_LE_S   = 5'd13;
    localparam logic [4:0] ALU_GE_S   = 5'd14;
    localparam logic [4:0] ALU_NE     = 5'd15;
    localparam logic [4:0] ALU_SHL    = 5'd16;
    localparam logic [4:0] ALU_SHR_S  = 5'd17;
    localparam logic [4:0] ALU_SHR_U  = 5'd18;
    localparam logic [4:0] ALU_ROTL   = 5'd19;
    localparam logic [4:0] ALU_ROTR   = 5'd20;

    localparam logic [1:0] PUSH_ALU   = 2'd0;
    localparam logic [1:0] PUSH_MEM   = 2'd1;
    localparam logic [1:0] PUSH_IMM   = 2'd2;
    localparam logic [1:0] PUSH_LOCAL = 2'd3;

    // parser steps
    localparam int          STEP_W         = 4;
    localparam logic [3:0] ST_MODULE      = 4'd0;
    localparam logic [3:0] ST_SEC_HEAD    = 4'd1;
    localparam logic [3:0] ST_SKIP        = 4'd2;
    localparam logic [3:0] ST_VEC_COUNT   = 4'd3;
    localparam logic [3:0] ST_BODY_SIZE   = 4'd4;
    localparam logic [3:0] ST_LOCAL_COUNT = 4'd5;
    localparam logic [3:0] ST_LOCAL_ENTRY = 4'd6;
    localparam logic [3:0] ST_INSTR       = 4'd7;
    localparam logic [3:0] ST_HALT        = 4'd8;

    typedef union packed {
        logic [WINDOW_W-1:0]          magic;  // header check
        logic [WINDOW_BYTES-1:0][7:0] bytes;  // bytes[0] opcode, rest immediates
    } window_t;

endpackage

`default_nettype wire

//--- decoder/wasm_opcode_decoder.sv
// i32 opcode table for code bodies, giving stack, ALU and constant controls plus instruction length
`timescale 1ns/1ps
`default_nettype none

module wasm_opcode_decoder
    import wasm_pkg::*;
(
    input  window_t              window,
    input  logic                 window_vld,
    input  logic                 body_active,
    output logic                 op_vld,
    output logic [1:0]           pop_num,
    output logic                 push_num,
    output logic [1:0]           push_select,
    output logic [4:0]           alu_op,
    output logic [VALUE_W-1:0]   constant,
    output logic [LEB_CNT_W-1:0] op_len,
    output logic                 block_open,
    output logic                 block_close,
    output logic                 trap
);

    logic [7:0]                 opcode;
    logic                       mem_op;
    logic [LEB_MAX_BYTES*8-1:0] leb_in;
    logic [LEB_CNT_W-1:0]       leb_cnt;
    logic [LEB_CNT_W-1:0]       len;
    logic                       supported;
    logic                       en;

    assign opcode = window.bytes[0];
    assign mem_op = (opcode == OP_I32_LOAD) || (opcode == OP_I32_STORE);
    assign leb_in = mem_op ? window.bytes[6:2] : window.bytes[5:1];  // hop the align byte

    leb128_decoder u_imm (
        .bytes    (leb_in),
        .value    (constant),
        .byte_cnt (leb_cnt)
    );

    always_comb begin
        case (opcode)
            OP_SELECT:    alu_op = ALU_SELECT;
            OP_I32_EQZ:   alu_op = ALU_EQZ;
            OP_I32_EQ:    alu_op = ALU_EQ;
            OP_I32_NE:    alu_op = ALU_NE;
            OP_I32_LT_S:  alu_op = ALU_LT_S;
            OP_I32_LT_U:  alu_op = ALU_LT_U;
            OP_I32_GT_S:  alu_op = ALU_GT_S;
            OP_I32_GT_U:  alu_op = ALU_GT_U;
            OP_I32_LE_S:  alu_op = ALU_LE_S;
            OP_I32_LE_U:  alu_op = ALU_LE_U;
            OP_I32_GE_S:  alu_op = ALU_GE_S;
            OP_I32_GE_U:  alu_op = ALU_GE_U;
            OP_I32_SUB:   alu_op = ALU_SUB;
            OP_I32_AND:   alu_op = ALU_AND;
            OP_I32_OR:    alu_op = ALU_OR;
            OP_I32_SHL:   alu_op = ALU_SHL;
            OP_I32_SHR_S: alu_op = ALU_SHR_S;
            OP_I32_SHR_U: alu_op = ALU_SHR_U;
            OP_I32_ROTL:  alu_op = ALU_ROTL;
            OP_I32_ROTR:  alu_op = ALU_ROTR;
            default:      alu_op = ALU_ADD;  // add, also address calc for local/mem
        endcase
    end

    always_comb begin
        pop_num     = 2'd0;
        push_num    = 1'b0;
        push_select = PUSH_ALU;
        len         = LEB_CNT_W'(1);
        supported   = 1'b1;
        case (opcode)
            OP_NOP, OP_END: len = LEB_CNT_W'(1);
            OP_BLOCK, OP_LOOP: len = LEB_CNT_W'(2);  // one blocktype byte
            OP_DROP: pop_num = 2'd1;
            OP_SELECT: begin
                pop_num  = 2'd3;
                push_num = 1'b1;
            end
            OP_LOCAL_GET: begin
                push_num    = 1'b1;
                push_select = PUSH_LOCAL;
                len         = LEB_CNT_W'(1) + leb_cnt;
            end
            OP_LOCAL_SET: begin
                pop_num = 2'd1;
                len     = LEB_CNT_W'(1) + leb_cnt;
            end
            OP_LOCAL_TEE: len = LEB_CNT_W'(1) + leb_cnt;  // top stays on stack
            OP_I32_CONST: begin
                push_num    = 1'b1;
                push_select = PUSH_IMM;
                len         = LEB_CNT_W'(1) + leb_cnt;
            end
            OP_I32_LOAD: begin
                pop_num     = 2'd1;
                push_num    = 1'b1;
                push_select = PUSH_MEM;
                len         = LEB_CNT_W'(2) + leb_cnt;
            end
            OP_I32_STORE: begin
                pop_num = 2'd2;
                len     = LEB_CNT_W'(2) + leb_cnt;
            end
            OP_I32_EQZ: begin
                pop_num  = 2'd1;
                push_num = 1'b1;
            end
            OP_I32_EQ, OP_I32_NE, OP_I32_LT_S, OP_I32_LT_U, OP_I32_GT_S, OP_I32_GT_U,
            OP_I32_LE_S, OP_I32_LE_U, OP_I32_GE_S, OP_I32_GE_U, OP_I32_ADD, OP_I32_SUB,
            OP_I32_AND, OP_I32_OR, OP_I32_SHL, OP_I32_SHR_S, OP_I32_SHR_U,
            OP_I32_ROTL, OP_I32_ROTR: begin
                pop_num  = 2'd2;
                push_num = 1'b1;
            end
            default: supported = 1'b0;  // unreachable lands here too
        endcase
    end

    assign en          = window_vld && body_active;
    assign op_vld      = en && supported;
    assign trap        = en && !supported;
    assign op_len      = op_vld ? len : '0;
    assign block_open  = op_vld && (opcode == OP_BLOCK || opcode == OP_LOOP);
    assign block_close = op_vld && (opcode == OP_END);

endmodule

`default_nettype wire

//--- parser/wasm_section_parser.sv
// module/section/code-body walker; computes the read advance and tracks bodies, locals and nesting
`timescale 1ns/1ps
`default_nettype none

module wasm_section_parser
    import wasm_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  window_t              window,
    input  logic                 window_vld,
    input  logic [LEB_CNT_W-1:0] op_len,
    input  logic                 block_open,
    input  logic                 block_close,
    input  logic                 trap,
    output logic [ADV_W-1:0]     advance,
    output logic                 body_active,
    output logic                 body_start,
    output logic [SLOT_W-1:0]    local_slots,
    output logic                 format_error,
    output logic                 done
);

    logic [STEP_W-1:0]          step;
    logic [ADV_W-1:0]           sec_size;
    logic [VALUE_W-1:0]         body_cnt;
    logic [VALUE_W-1:0]         body_idx;
    logic [VALUE_W-1:0]         loc_cnt;
    logic [VALUE_W-1:0]         loc_idx;
    logic [DEPTH_W-1:0]         depth;
    logic                       first_instr;
    logic [LEB_MAX_BYTES*8-1:0] leb_in;
    logic [VALUE_W-1:0]         leb_value;
    logic [LEB_CNT_W-1:0]       leb_cnt;
    logic                       magic_ok;
    logic                       error_hit;
    logic                       last_body;

    // section size sits behind the id byte
    assign leb_in = (step == ST_SEC_HEAD) ? window.bytes[5:1] : window.bytes[4:0];

    leb128_decoder u_field (
        .bytes    (leb_in),
        .value    (leb_value),
        .byte_cnt (leb_cnt)
    );

    assign magic_ok    = (window.magic == WASM_MAGIC_VERSION);
    assign body_active = (step == ST_INSTR);
    assign body_start  = window_vld && body_active && first_instr;
    assign done        = (step == ST_HALT);
    assign error_hit   = window_vld && ((step == ST_MODULE && !magic_ok) || trap);
    assign last_body   = (body_idx == body_cnt - 1'b1);

    always_comb begin
        case (step)
            ST_MODULE:      advance = magic_ok ? ADV_W'(WINDOW_BYTES) : '0;
            ST_SEC_HEAD:    advance = ADV_W'(leb_cnt) + 1'b1;
            ST_SKIP:        advance = sec_size;  // whole payload in one jump
            ST_VEC_COUNT,
            ST_BODY_SIZE,
            ST_LOCAL_COUNT: advance = ADV_W'(leb_cnt);
            ST_LOCAL_ENTRY: advance = ADV_W'(leb_cnt) + 1'b1;  // count + valtype
            ST_INSTR:       advance = ADV_W'(op_len);
            default:        advance = '0;
        endcase
        if (!window_vld) begin
            advance = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step         <= ST_MODULE;
            sec_size     <= '0;
            body_cnt     <= '0;
            body_idx     <= '0;
            loc_cnt      <= '0;
            loc_idx      <= '0;
            local_slots  <= '0;
            depth        <= '0;
            first_instr  <= 1'b0;
            format_error <= 1'b0;
        end else if (window_vld) begin
            if (error_hit) begin
                format_error <= 1'b1;
                step         <= ST_HALT;
            end else begin
                case (step)
                    ST_MODULE: step <= ST_SEC_HEAD;
                    ST_SEC_HEAD: begin
                        sec_size <= ADV_W'(leb_value);
                        if (window.bytes[0] == SEC_CODE) begin
                            step <= ST_VEC_COUNT;
                        end else if (leb_value != '0) begin
                            step <= ST_SKIP;  // empty payload needs no jump
                        end
                    end
                    ST_SKIP: step <= ST_SEC_HEAD;
                    ST_VEC_COUNT: begin
                        body_cnt <= leb_value;
                        body_idx <= '0;
                        step     <= (leb_value == '0) ? ST_HALT : ST_BODY_SIZE;
                    end
                    ST_BODY_SIZE: step <= ST_LOCAL_COUNT;
                    ST_LOCAL_COUNT: begin
                        loc_cnt     <= leb_value;
                        loc_idx     <= '0;
                        local_slots <= '0;
                        first_instr <= 1'b1;
                        step        <= (leb_value == '0) ? ST_INSTR : ST_LOCAL_ENTRY;
                    end
                    ST_LOCAL_ENTRY: begin
                        local_slots <= local_slots + SLOT_W'(leb_value);
                        loc_idx     <= loc_idx + 1'b1;
                        if (loc_idx == loc_cnt - 1'b1) begin
                            step <= ST_INSTR;
                        end
                    end
                    ST_INSTR: begin
                        first_instr <= 1'b0;
                        if (block_open) begin
                            depth <= depth + 1'b1;
                        end else if (block_close) begin
                            if (depth != '0) begin
                                depth <= depth - 1'b1;
                            end else if (last_body) begin
                                step <= ST_HALT;  // end of code section
                            end else begin
                                body_idx <= body_idx + 1'b1;
                                step     <= ST_BODY_SIZE;
                            end
                        end
                    end
                    default: step <= ST_HALT;
                endcase
            end
        end
    end

    a_depth_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        block_open |-> depth != '1);

    // every accepted window must move the pointer, or the stream stalls
    a_advance_moves: assert property (@(posedge clk) disable iff (!rst_n)
        (window_vld && !done && !error_hit) |-> advance != '0);

endmodule

`default_nettype wire

//--- rtl/leb128_decoder.sv
// combinational unsigned LEB128 field decoder shared by the section parser and the opcode decoder
`timescale 1ns/1ps
`default_nettype none

module leb128_decoder
    import wasm_pkg::*;
(
    input  logic [LEB_MAX_BYTES*8-1:0] bytes,
    output logic [VALUE_W-1:0]         value,
    output logic [LEB_CNT_W-1:0]       byte_cnt
);

    logic found;

    always_comb begin
        value    = '0;
        byte_cnt = LEB_CNT_W'(LEB_MAX_BYTES);  // unterminated field takes all five
        found    = 1'b0;
        for (int i = 0; i < LEB_MAX_BYTES; i++) begin
            if (!found) begin
                value = value | (VALUE_W'(bytes[8*i +: 7]) << (7 * i));
                if (!bytes[8*i+7]) begin
                    byte_cnt = LEB_CNT_W'(i + 1);
                    found    = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/wasm_ctrl_unit.sv
// top of the wasm control unit front end, joining the section parser and the opcode decoder
`timescale 1ns/1ps
`default_nettype none

module wasm_ctrl_unit
    import wasm_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  window_t            window,
    input  logic               window_vld,
    output logic [ADV_W-1:0]   advance,
    output logic               op_vld,
    output logic [1:0]         pop_num,
    output logic               push_num,
    output logic [1:0]         push_select,
    output logic [4:0]         alu_op,
    output logic [VALUE_W-1:0] constant,
    output logic               body_start,
    output logic [SLOT_W-1:0]  local_slots,
    output logic               format_error,
    output logic               done
);

    logic [LEB_CNT_W-1:0] op_len;
    logic                 block_open;
    logic                 block_close;
    logic                 trap;
    logic                 body_active;

    wasm_section_parser u_parser (
        .clk          (clk),
        .rst_n        (rst_n),
        .window       (window),
        .window_vld   (window_vld),
        .op_len       (op_len),
        .block_open   (block_open),
        .block_close  (block_close),
        .trap         (trap),
        .advance      (advance),
        .body_active  (body_active),
        .body_start   (body_start),
        .local_slots  (local_slots),
        .format_error (format_error),
        .done         (done)
    );

    wasm_opcode_decoder u_decoder (
        .window      (window),
        .window_vld  (window_vld),
        .body_active (body_active),
        .op_vld      (op_vld),
        .pop_num     (pop_num),
        .push_num    (push_num),
        .push_select (push_select),
        .alu_op      (alu_op),
        .constant    (constant),
        .op_len      (op_len),
        .block_open  (block_open),
        .block_close (block_close),
        .trap        (trap)
    );

endmodule

`default_nettype wire

//--- tests/wasm_program.svh
// module image builders for the control unit testbench, writing bytes, LEB128 fields and code bodies
`ifndef WASM_PROGRAM_SVH
`define WASM_PROGRAM_SVH

task automatic start_image();
    for (int i = 0; i < MEM_SIZE; i++) begin
        mem[i] = 8'h00;
    end
    img_len = 0;
    instr_q.delete();
    body_addr_q.delete();
    body_slots_q.delete();
endtask

task automatic put_byte(input logic [7:0] b);
    mem[img_len] = b;
    img_len++;
endtask

task automatic put_leb(input logic [31:0] value);
    logic [31:0] rest;
    rest = value;
    while (rest > 127) begin
        put_byte({1'b1, rest[6:0]});
        rest = rest >> 7;
    end
    put_byte({1'b0, rest[6:0]});
endtask

// random value whose top set bit is width-1, so its LEB length is known
function automatic logic [31:0] rand_bits(input int width);
    logic [63:0] mask;
    logic [31:0] v;
    mask = (64'd1 << width) - 1;
    v = $random(seed);
    return (v & mask[31:0]) | (32'd1 << (width - 1));
endfunction

task automatic put_magic(input logic [7:0] version);
    logic [31:0] tag;
    tag = 32'h6d73_6100;  // "\0asm" little endian
    for (int i = 0; i < 4; i++) begin
        put_byte(tag[8*i +: 8]);
    end
    put_byte(version);
    repeat (3) put_byte(8'h00);
endtask

task automatic put_custom(input int size);
    put_byte(8'h00);
    put_leb(size);
    repeat (size) put_byte(8'($random(seed)));
endtask

// two byte padded size field, filled in once the payload is known
task automatic size_open(output int at);
    at = img_len;
    img_len += 2;
endtask

task automatic size_close(input int at);
    int size;
    size = img_len - at - 2;
    mem[at]     = 8'h80 | 8'(size & 127);
    mem[at + 1] = 8'((size >> 7) & 127);
endtask

task automatic put_locals(input int entries);
    int total;
    int cnt;
    total = 0;
    put_leb(entries);
    for (int i = 0; i < entries; i++) begin
        cnt = 1 + ($random(seed) & 63);
        total += cnt;
        put_leb(cnt);
        put_byte(8'h7f);  // i32
    end
    body_addr_q.push_back(img_len);
    body_slots_q.push_back(total);
endtask

task automatic put_op(input logic [7:0] op);
    instr_q.push_back(img_len);
    put_byte(op);
endtask

task automatic put_op_imm(input logic [7:0] op, input logic [31:0] value);
    instr_q.push_back(img_len);
    put_byte(op);
    put_leb(value);
endtask

task automatic put_op_mem(input logic [7:0] op, input logic [31:0] offset);
    instr_q.push_back(img_len);
    put_byte(op);
    put_byte(8'h02);  // align field
    put_leb(offset);
endtask

task automatic put_op_block(input logic [7:0] op);
    instr_q.push_back(img_len);
    put_byte(op);
    put_byte(8'h40);  // empty blocktype
endtask

`endif

//--- tests/tb_wasm_ctrl_unit.sv
// testbench for the wasm control unit, streaming generated module images through the read window
`timescale 1ns/1ps
`default_nettype none

module tb_wasm_ctrl_unit
    import wasm_pkg::*;
();

    localparam int MEM_SIZE = 2048;

    logic                clk = 1'b0;
    logic                rst_n = 1'b0;
    logic [WINDOW_W-1:0] window = '0;
    logic                window_vld = 1'b0;
    logic [ADV_W-1:0]    advance;
    logic                op_vld;
    logic [1:0]          pop_num;
    logic                push_num;
    logic [1:0]          push_select;
    logic [4:0]          alu_op;
    logic [VALUE_W-1:0]  constant;
    logic                body_start;
    logic [SLOT_W-1:0]   local_slots;
    logic                format_error;
    logic                done;

    logic [7:0] mem [MEM_SIZE];
    int         img_len = 0;
    int         seed = 32;
    int         win_ptr = 0;  // address of the window on the bus
    int         next_ptr;
    int         instr_q[$];
    int         body_addr_q[$];
    int         body_slots_q[$];
    int         checks = 0;
    int         mismatches = 0;
    int         failures = 0;
    int         cycle_count = 0;
    int         run_start = 0;
    int         run_limit = 200;

    wasm_ctrl_unit i_wasm_ctrl_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .window       (window),
        .window_vld   (window_vld),
        .advance      (advance),
        .op_vld       (op_vld),
        .pop_num      (pop_num),
        .push_num     (push_num),
        .push_select  (push_select),
        .alu_op       (alu_op),
        .constant     (constant),
        .body_start   (body_start),
        .local_slots  (local_slots),
        .format_error (format_error),
        .done         (done)
    );

    always #5 clk = ~clk;

    `include "wasm_program.svh"

    function automatic logic [7:0] mem_byte(input int at);
        if (at < 0 || at >= MEM_SIZE) begin
            return 8'h00;
        end
        return mem[at];
    endfunction

    function automatic logic [WINDOW_W-1:0] read_window(input int at);
        logic [WINDOW_W-1:0] w;
        for (int i = 0; i < WINDOW_BYTES; i++) begin
            w[8*i +: 8] = mem_byte(at + i);
        end
        return w;
    endfunction

    function automatic int leb_read(input int at, output logic [31:0] value);
        logic [7:0] b;
        value = '0;
        for (int i = 0; i < 5; i++) begin
            b = mem_byte(at + i);
            value = value | (32'(b[6:0]) << (7 * i));
            if (!b[7]) begin
                return i + 1;
            end
        end
        return 5;
    endfunction

    // expected controls of the instruction at an address, returns its length or 0
    function automatic int ref_decode(input int at, output logic [1:0] pop, output logic push,
                                      output logic [1:0] sel, output logic [4:0] alu,
                                      output logic [31:0] imm, output logic has_imm);
        logic [7:0] op;
        logic       binary;
        int         imm_at;
        int         len;
        op     = mem_byte(at);
        pop    = 2'd0;
        push   = 1'b0;
        sel    = PUSH_ALU;
        alu    = ALU_ADD;
        imm    = '0;
        binary = 1'b1;
        imm_at = 0;
        len    = 1;
        case (op)
            OP_I32_EQ:    alu = ALU_EQ;
            OP_I32_NE:    alu = ALU_NE;
            OP_I32_LT_S:  alu = ALU_LT_S;
            OP_I32_LT_U:  alu = ALU_LT_U;
            OP_I32_GT_S:  alu = ALU_GT_S;
            OP_I32_GT_U:  alu = ALU_GT_U;
            OP_I32_LE_S:  alu = ALU_LE_S;
            OP_I32_LE_U:  alu = ALU_LE_U;
            OP_I32_GE_S:  alu = ALU_GE_S;
            OP_I32_GE_U:  alu = ALU_GE_U;
            OP_I32_ADD:   alu = ALU_ADD;
            OP_I32_SUB:   alu = ALU_SUB;
            OP_I32_AND:   alu = ALU_AND;
            OP_I32_OR:    alu = ALU_OR;
            OP_I32_SHL:   alu = ALU_SHL;
            OP_I32_SHR_S: alu = ALU_SHR_S;
            OP_I32_SHR_U: alu = ALU_SHR_U;
            OP_I32_ROTL:  alu = ALU_ROTL;
            OP_I32_ROTR:  alu = ALU_ROTR;
            default:      binary = 1'b0;
        endcase
        if (binary) begin
            pop  = 2'd2;
            push = 1'b1;
        end
        case (op)
            OP_NOP, OP_END:    len = 1;
            OP_BLOCK, OP_LOOP: len = 2;
            OP_DROP:           pop = 2'd1;
            OP_SELECT: begin
                pop  = 2'd3;
                push = 1'b1;
                alu  = ALU_SELECT;
            end
            OP_I32_EQZ: begin
                pop  = 2'd1;
                push = 1'b1;
                alu  = ALU_EQZ;
            end
            OP_LOCAL_GET: begin
                push   = 1'b1;
                sel    = PUSH_LOCAL;
                imm_at = 1;
            end
            OP_LOCAL_SET: begin
                pop    = 2'd1;
                imm_at = 1;
            end
            OP_LOCAL_TEE: imm_at = 1;
            OP_I32_CONST: begin
                push   = 1'b1;
                sel    = PUSH_IMM;
                imm_at = 1;
            end
            OP_I32_LOAD: begin
                pop    = 2'd1;
                push   = 1'b1;
                sel    = PUSH_MEM;
                imm_at = 2;  // past the align byte
            end
            OP_I32_STORE: begin
                pop    = 2'd2;
                imm_at = 2;
            end
            default: begin
                if (!binary) begin
                    len = 0;  // unreachable or unknown
                end
            end
        endcase
        has_imm = (imm_at != 0);
        if (has_imm) begin
            len = imm_at + leb_read(at + imm_at, imm);
        end
        return len;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic compare_instr();
        logic [1:0]  pop;
        logic        push;
        logic [1:0]  sel;
        logic [4:0]  alu;
        logic [31:0] imm;
        logic        has_imm;
        int          len;
        string       tag;
        tag = $sformatf("opcode %02h at %0d", mem_byte(win_ptr), win_ptr);
        if (instr_q.size() == 0) begin
            $display("op_vld at %0t for %s, but no instruction was expected", $time, tag);
            failures++;
            return;
        end
        check_value(win_ptr, instr_q.pop_front(), {tag, " instruction address"});
        len = ref_decode(win_ptr, pop, push, sel, alu, imm, has_imm);
        check_value(advance, len, {tag, " advance"});
        check_value(pop_num, pop, {tag, " pop_num"});
        check_value(push_num, push, {tag, " push_num"});
        if (push) begin
            check_value(push_select, sel, {tag, " push_select"});
        end
        if (push && sel == PUSH_ALU) begin
            check_value(alu_op, alu, {tag, " alu_op"});
        end
        if (has_imm) begin
            check_value(constant, imm, {tag, " constant"});
        end
    endtask

    // memory model: presents a window at the pointer, moves it by the answered advance
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            win_ptr    <= 0;
            window_vld <= 1'b0;
            window     <= '0;
        end else begin
            next_ptr = window_vld ? win_ptr + int'(advance) : win_ptr;
            win_ptr    <= next_ptr;
            window_vld <= (($random(seed) & 3) != 0);  // idle about one cycle in four
            window     <= read_window(next_ptr);
        end
    end

    always @(posedge clk) begin
        if (rst_n && window_vld) begin
            if (done) begin
                check_value(advance, 0, "advance after done");
                check_value(op_vld, 0, "op_vld after done");
            end
            if (body_start) begin
                if (body_addr_q.size() == 0) begin
                    $display("body_start at %0t, pointer %0d, but no body was expected",
                             $time, win_ptr);
                    failures++;
                end else begin
                    check_value(win_ptr, body_addr_q.pop_front(), "body start address");
                    check_value(local_slots, body_slots_q.pop_front(), "local_slots");
                end
            end
            if (op_vld) begin
                compare_instr();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count - run_start > run_limit) begin
            $display("timeout at %0t: done did not rise within %0d cycles", $time, run_limit);
            $display("%0d checks, %0d mismatches, %0d other failures",
                     checks, mismatches, failures);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic hold_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
    endtask

    task automatic run_image(input logic expect_err);
        run_start <= cycle_count;
        run_limit <= 4 * img_len + 200;
        @(posedge clk);
        rst_n <= 1'b1;
        while (done !== 1'b1) begin
            @(posedge clk);
        end
        repeat (6) @(posedge clk);  // a few windows after done
        check_value(format_error, expect_err, "format_error at end of image");
        check_value(done, 1'b1, "done at end of image");
        if (instr_q.size() != 0 || body_addr_q.size() != 0) begin
            $display("%0d instructions and %0d bodies were never decoded",
                     instr_q.size(), body_addr_q.size());
            failures++;
        end
    endtask

    initial begin
        int sec_at;
        int body_at;
        int op;
        // wrong version word, nothing after it may decode
        hold_reset();
        start_image();
        put_magic(8'h02);
        put_byte(SEC_CODE);
        put_leb(4);
        put_leb(1);
        put_leb(2);
        put_leb(0);
        put_byte(OP_END);
        run_image(1'b1);

        hold_reset();
        start_image();
        put_magic(8'h01);
        put_custom(0);
        repeat (3) put_custom($random(seed) & 255);
        put_byte(SEC_CODE);
        size_open(sec_at);
        put_leb(3);
        size_open(body_at);
        put_locals(3);
        for (int i = 1; i <= 5; i++) begin
            put_op_imm(OP_I32_CONST, rand_bits(i == 5 ? 32 : 7 * i));
        end
        repeat (3) put_op_imm(OP_I32_CONST, rand_bits(1 + ($random(seed) & 31)));
        put_op(OP_NOP);
        put_op(OP_DROP);
        put_op(OP_SELECT);
        for (op = OP_I32_EQZ; op <= OP_I32_GE_U; op++) begin
            put_op(op);
        end
        for (op = OP_I32_SHL; op <= OP_I32_ROTR; op++) begin
            put_op(op);
        end
        put_op(OP_I32_ADD);
        put_op(OP_I32_SUB);
        put_op(OP_I32_AND);
        put_op(OP_I32_OR);
        put_op_imm(OP_LOCAL_GET, $random(seed) & 7);
        put_op_imm(OP_LOCAL_SET, rand_bits(8));
        put_op_imm(OP_LOCAL_TEE, 1);
        put_op_mem(OP_I32_LOAD, rand_bits(1 + ($random(seed) & 31)));
        put_op_mem(OP_I32_STORE, rand_bits(32));
        put_op_block(OP_BLOCK);
        put_op_block(OP_LOOP);
        put_op(OP_END);
        put_op(OP_NOP);
        put_op(OP_END);
        put_op(OP_END);  // closes body 0
        size_close(body_at);
        size_open(body_at);
        put_locals(0);
        put_op_block(OP_BLOCK);
        put_op(OP_END);
        put_op(OP_END);
        size_close(body_at);
        size_open(body_at);
        put_locals(1);
        put_op_imm(OP_I32_CONST, rand_bits(12));
        put_op(OP_DROP);
        put_op(OP_END);
        size_close(body_at);
        size_close(sec_at);
        put_custom(20);  // past the code section, never read
        run_image(1'b0);

        // unreachable in the middle of a body
        hold_reset();
        start_image();
        put_magic(8'h01);
        put_custom(3);
        put_byte(SEC_CODE);
        size_open(sec_at);
        put_leb(1);
        size_open(body_at);
        put_locals(2);
        put_op_imm(OP_I32_CONST, rand_bits(9));
        put_op(OP_NOP);
        put_byte(OP_UNREACHABLE);
        put_byte(OP_END);
        size_close(body_at);
        size_close(sec_at);
        run_image(1'b1);

        $display("%0d checks, %0d mismatches, %0d other failures", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+tests
common/wasm_pkg.sv
rtl/leb128_decoder.sv
decoder/wasm_opcode_decoder.sv
parser/wasm_section_parser.sv
rtl/wasm_ctrl_unit.sv
tests/tb_wasm_ctrl_unit.sv
